// ==== hdl/apuPkg.sv ====
package apuPkg;

localparam int RAM_DEPTH = 256;
localparam int ADDR_W = 8;
localparam int DATA_W = 8;
localparam int LEVEL_W = 8;

localparam int DELTA_RATE = 4;                       // Clocks per played bit.
localparam int DELTA_RATE_W = $clog2(DELTA_RATE);
localparam int DELTA_RESET_LEVEL = 64;
localparam int DELTA_MAX = 126;                      // Top of the delta range.

// High steps of the pulse sequencer, indexed by duty setting.
localparam logic [3:0][7:0] DUTY_PATTERN = {
	8'b0011_1111,
	8'b0000_1111,
	8'b0000_0011,
	8'b0000_0001
};

typedef enum logic [1:0] {opWriteRam, opReadRam, opWriteReg} hostOp;

typedef enum logic [2:0] {
	regPulsePeriod = 3'd0,
	regPulseDuty   = 3'd1,                           // Low 2 bits.
	regPulseVolume = 3'd2,                           // Low 4 bits.
	regDeltaStart  = 3'd3,
	regDeltaLength = 3'd4,                           // Byte count.
	regDeltaGo     = 3'd5
} regAddr;

typedef enum logic [1:0] {hIdle, hWaitGrant, hReadData} hostState;

typedef enum logic [1:0] {dIdle, dFetch, dWaitData, dPlay} deltaState;

endpackage

// ==== hdl/sampleBusIf.sv ====
interface sampleBusIf import apuPkg::*; ();

logic req;                          // Held with we, addr and wdata until gnt.
logic we;
logic [ADDR_W-1:0] addr;
logic [DATA_W-1:0] wdata;
logic gnt;                          // Single cycle.
logic rvalid;                       // One cycle after a read gnt.
logic [DATA_W-1:0] rdata;

modport master (
	output req, we, addr, wdata,
	input gnt, rvalid, rdata
);

modport arbiter (
	input req, we, addr, wdata,
	output gnt, rvalid, rdata
);

endinterface

// ==== hdl/sampleRam.sv ====
module sampleRam import apuPkg::*; (
	input logic clk,
	input logic en,
	input logic we,
	input logic [ADDR_W-1:0] addr,
	input logic [DATA_W-1:0] wdata,
	output logic [DATA_W-1:0] rdata
);

logic [DATA_W-1:0] mem [RAM_DEPTH];

always_ff @(posedge clk) begin
	if (en) begin
		if (we)
			mem[addr] <= wdata;
		else
			rdata <= mem[addr];     // Registered read.
	end
end

endmodule

// ==== hdl/busArbiter.sv ====
module busArbiter import apuPkg::*; (
	input logic clk,
	input logic rstN,
	sampleBusIf.arbiter hostBus,
	sampleBusIf.arbiter deltaBus,
	output logic ramEn,
	output logic ramWe,
	output logic [ADDR_W-1:0] ramAddr,
	output logic [DATA_W-1:0] ramWdata,
	input logic [DATA_W-1:0] ramRdata
);

logic hostWins, deltaWins;
logic lastDelta;                    // Delta master was granted last.
logic readValid;                    // Read issued in the previous cycle.
logic readToDelta;                  // Owner of that read.

// Round-robin: on a tie the master not granted last takes the cycle.
assign hostWins = hostBus.req && (!deltaBus.req || lastDelta);
assign deltaWins = deltaBus.req && !hostWins;

assign hostBus.gnt = hostWins;
assign deltaBus.gnt = deltaWins;

assign ramEn = hostWins || deltaWins;
assign ramWe = hostWins ? hostBus.we : (deltaWins && deltaBus.we);
assign ramAddr = deltaWins ? deltaBus.addr : hostBus.addr;
assign ramWdata = deltaWins ? deltaBus.wdata : hostBus.wdata;

assign hostBus.rvalid = readValid && !readToDelta;
assign deltaBus.rvalid = readValid && readToDelta;
assign hostBus.rdata = ramRdata;
assign deltaBus.rdata = ramRdata;

always_ff @(posedge clk or negedge rstN) begin
	if (!rstN) begin
		lastDelta <= 1'b1;          // Host wins the first tie.
		readValid <= 1'b0;
		readToDelta <= 1'b0;
	end else begin
		if (ramEn)
			lastDelta <= deltaWins;
		readValid <= ramEn && !ramWe;
		readToDelta <= deltaWins;
	end
end

endmodule

// ==== hdl/hostPort.sv ====
module hostPort import apuPkg::*; (
	input logic clk,
	input logic rstN,
	input logic cmdValid,
	input hostOp cmdOp,
	input logic [ADDR_W-1:0] cmdAddr,
	input logic [DATA_W-1:0] cmdData,
	output logic cmdReady,
	output logic rdValid,
	output logic [DATA_W-1:0] rdData,
	sampleBusIf.master bus,
	output logic [7:0] pulsePeriod,
	output logic [1:0] pulseDuty,
	output logic [3:0] pulseVolume,
	output logic [ADDR_W-1:0] deltaStart,
	output logic [7:0] deltaLength,
	output logic deltaGo
);

hostState state;
logic accept;
logic busWe;
logic [ADDR_W-1:0] busAddr;
logic [DATA_W-1:0] busWdata;

assign cmdReady = state == hIdle;
assign accept = cmdValid && cmdReady;

assign bus.req = state == hWaitGrant;
assign bus.we = busWe;
assign bus.addr = busAddr;
assign bus.wdata = busWdata;

always_ff @(posedge clk or negedge rstN) begin
	if (!rstN) begin
		state <= hIdle;
		rdValid <= 1'b0;
		deltaGo <= 1'b0;
		pulsePeriod <= '0;
		pulseDuty <= '0;
		pulseVolume <= '0;          // Silent pulse after reset.
		deltaStart <= '0;
		deltaLength <= '0;
	end else begin
		rdValid <= 1'b0;
		deltaGo <= 1'b0;
		case (state)
			hIdle:
				if (accept) begin
					case (cmdOp)
						opWriteRam, opReadRam: state <= hWaitGrant;
						opWriteReg:
							case (regAddr'(cmdAddr[2:0]))
								regPulsePeriod: pulsePeriod <= cmdData;
								regPulseDuty: pulseDuty <= cmdData[1:0];
								regPulseVolume: pulseVolume <= cmdData[3:0];
								regDeltaStart: deltaStart <= ADDR_W'(cmdData);
								regDeltaLength: deltaLength <= cmdData;
								regDeltaGo: deltaGo <= 1'b1;
								default: ;
							endcase
						default: ;
					endcase
				end
			hWaitGrant:
				if (bus.gnt)
					state <= busWe ? hIdle : hReadData;
			hReadData:
				if (bus.rvalid) begin
					rdValid <= 1'b1;    // Two cycles after gnt.
					state <= hIdle;
				end
			default: state <= hIdle;
		endcase
	end
end

// Request fields are stable from acceptance until gnt.
always_ff @(posedge clk) begin
	if (accept) begin
		busWe <= cmdOp == opWriteRam;
		busAddr <= cmdAddr;
		busWdata <= cmdData;
	end
	if (state == hReadData && bus.rvalid)
		rdData <= bus.rdata;
end

endmodule

// ==== hdl/pulseChannel.sv ====
module pulseChannel import apuPkg::*; (
	input logic clk,
	input logic rstN,
	input logic [7:0] period,
	input logic [1:0] duty,
	input logic [3:0] volume,
	output logic [3:0] pulseLevel
);

logic [7:0] timer;
logic [2:0] step;                   // Eight steps per wave cycle.
logic [7:0] pattern;

assign pattern = DUTY_PATTERN[duty];
assign pulseLevel = pattern[step] ? volume : 4'd0;

always_ff @(posedge clk or negedge rstN) begin
	if (!rstN) begin
		timer <= '0;
		step <= '0;
	end else begin
		// A period lowered mid-count ends the current step at once.
		if (timer >= period) begin
			timer <= '0;
			step <= step + 3'd1;
		end else begin
			timer <= timer + 8'd1;
		end
	end
end

endmodule

// ==== hdl/deltaChannel.sv ====
module deltaChannel import apuPkg::*; (
	input logic clk,
	input logic rstN,
	input logic go,
	input logic [ADDR_W-1:0] startAddr,
	input logic [7:0] length,
	sampleBusIf.master bus,
	output logic [6:0] deltaLevel,
	output logic busy
);

deltaState state;
logic [ADDR_W-1:0] fetchAddr;
logic [7:0] bytesLeft;
logic [DATA_W-1:0] shiftReg;
logic [2:0] bitCount;
logic [DELTA_RATE_W-1:0] rateCnt;
logic bitDone;

// Step of two per bit, skipped when it would leave the range.
function automatic logic [6:0] nextLevel(input logic [6:0] cur, input logic up);
	logic [6:0] res;
	res = cur;
	if (up && cur <= 7'(DELTA_MAX - 2))
		res = cur + 7'd2;
	else if (!up && cur >= 7'd2)
		res = cur - 7'd2;
	return res;
endfunction

assign busy = state != dIdle;
assign bitDone = state == dPlay && rateCnt == DELTA_RATE_W'(DELTA_RATE - 1);

assign bus.req = state == dFetch;
assign bus.we = 1'b0;               // Read-only master.
assign bus.addr = fetchAddr;
assign bus.wdata = '0;

always_ff @(posedge clk or negedge rstN) begin
	if (!rstN) begin
		state <= dIdle;
		fetchAddr <= '0;
		bytesLeft <= '0;
		bitCount <= '0;
		rateCnt <= '0;
		deltaLevel <= 7'(DELTA_RESET_LEVEL);
	end else begin
		case (state)
			dIdle:
				if (go && length != 8'd0) begin
					fetchAddr <= startAddr;
					bytesLeft <= length;
					deltaLevel <= 7'(DELTA_RESET_LEVEL);
					state <= dFetch;
				end
			dFetch:
				if (bus.gnt)
					state <= dWaitData;
			dWaitData:
				if (bus.rvalid) begin
					bitCount <= '0;
					rateCnt <= '0;
					state <= dPlay;
				end
			dPlay:
				if (bitDone) begin
					rateCnt <= '0;
					deltaLevel <= nextLevel(deltaLevel, shiftReg[0]);
					bitCount <= bitCount + 3'd1;
					if (bitCount == 3'd7) begin
						fetchAddr <= fetchAddr + 1'b1;
						bytesLeft <= bytesLeft - 8'd1;
						state <= (bytesLeft == 8'd1) ? dIdle : dFetch;
					end
				end else begin
					rateCnt <= rateCnt + 1'b1;
				end
			default: state <= dIdle;
		endcase
	end
end

// LSB first.
always_ff @(posedge clk) begin
	if (state == dWaitData && bus.rvalid)
		shiftReg <= bus.rdata;
	else if (bitDone)
		shiftReg <= shiftReg >> 1;
end

endmodule

// ==== hdl/apuMixPwm.sv ====
module apuMixPwm import apuPkg::*; #(
	parameter int N = LEVEL_W
) (
	input logic clk,
	input logic rstN,
	input logic [3:0] pulseLevel,
	input logic [6:0] deltaLevel,
	output logic [N-1:0] level,
	output logic aout
);

logic [N-1:0] cnt;                  // Free-running, wraps every 2**N cycles.

always_ff @(posedge clk or negedge rstN) begin
	if (!rstN) begin
		level <= N'(DELTA_RESET_LEVEL);
		cnt <= '0;
		aout <= 1'b0;
	end else begin
		level <= N'(deltaLevel) + N'(pulseLevel);
		cnt <= cnt + 1'b1;
		aout <= cnt < level;        // High for level counts per period.
	end
end

endmodule

// ==== hdl/apuSystem.sv ====
module apuSystem import apuPkg::*; (
	input logic clk,
	input logic rstN,
	input logic cmdValid,
	input hostOp cmdOp,
	input logic [ADDR_W-1:0] cmdAddr,
	input logic [DATA_W-1:0] cmdData,
	output logic cmdReady,
	output logic rdValid,
	output logic [DATA_W-1:0] rdData,
	output logic [LEVEL_W-1:0] level,
	output logic aout,
	output logic deltaBusy
);

sampleBusIf hostBus ();
sampleBusIf deltaBus ();

logic [7:0] pulsePeriod;
logic [1:0] pulseDuty;
logic [3:0] pulseVolume, pulseLevel;
logic [ADDR_W-1:0] deltaStart;
logic [7:0] deltaLength;
logic deltaGo;
logic [6:0] deltaLevel;
logic ramEn, ramWe;
logic [ADDR_W-1:0] ramAddr;
logic [DATA_W-1:0] ramWdata, ramRdata;

hostPort host0 (.bus(hostBus), .*);

deltaChannel delta0 (.go(deltaGo), .startAddr(deltaStart), .length(deltaLength),
	.bus(deltaBus), .busy(deltaBusy), .*);

pulseChannel pulse0 (.period(pulsePeriod), .duty(pulseDuty), .volume(pulseVolume), .*);

busArbiter arb0 (.*);

sampleRam ram0 (.clk(clk), .en(ramEn), .we(ramWe), .addr(ramAddr),
	.wdata(ramWdata), .rdata(ramRdata));

apuMixPwm #(.N(LEVEL_W)) pwm0 (.*);

endmodule

// ==== bench/apuSystem_asserts.sv ====
module arbiterAsserts (
	input logic clk,
	input logic rstN,
	sampleBusIf.arbiter hostBus,
	sampleBusIf.arbiter deltaBus
);

timeunit 1ns;
timeprecision 1ns;

oneGrant: assert property (@(posedge clk) disable iff (!rstN)
	!(hostBus.gnt && deltaBus.gnt))
	else $error("Both masters granted in the same cycle.");

// A master keeps its request and its fields until gnt.
hostHold: assert property (@(posedge clk) disable iff (!rstN)
	hostBus.req && !hostBus.gnt |=> hostBus.req
		&& $stable({hostBus.we, hostBus.addr, hostBus.wdata}))
	else $error("Host request dropped or changed before its grant.");

deltaHold: assert property (@(posedge clk) disable iff (!rstN)
	deltaBus.req && !deltaBus.gnt |=> deltaBus.req && $stable(deltaBus.addr))
	else $error("Delta request dropped or changed before its grant.");

hostReadData: assert property (@(posedge clk) disable iff (!rstN)
	hostBus.gnt && !hostBus.we |=> hostBus.rvalid)
	else $error("Host read grant not followed by rvalid.");

deltaReadData: assert property (@(posedge clk) disable iff (!rstN)
	deltaBus.gnt && !deltaBus.we |=> deltaBus.rvalid)
	else $error("Delta read grant not followed by rvalid.");

endmodule

bind busArbiter arbiterAsserts arbChecks (
	.clk(clk),
	.rstN(rstN),
	.hostBus(hostBus),
	.deltaBus(deltaBus)
);

// ==== bench/apuSystemTb.sv ====
module apuSystemTb import apuPkg::*; ();

timeunit 1ns;
timeprecision 1ns;

localparam int CLK_PERIOD = 100;
localparam int NUM_BYTES = 8;
localparam int TABLE_LEN = 2 * NUM_BYTES;             // Writes, then reads.
localparam logic [7:0] SAMPLE_BASE = 8'h10;
localparam int PULSE_PERIOD = 3;
localparam int CMD_CYCLES = 12;                      // Longest command under contention.
localparam int PLAY_CYCLES = NUM_BYTES * (8 * DELTA_RATE + 4);
localparam int RUN_CYCLES = 8 + 3 * TABLE_LEN * CMD_CYCLES + 2 * PLAY_CYCLES
	+ 16 * (PULSE_PERIOD + 1) + 256 + 50;

typedef struct {
	hostOp op;
	logic [7:0] addr;
	logic [7:0] data;
	logic [7:0] expRead;
} cmdEntry;

logic clk, rstN, cmdValid, cmdReady, rdValid, aout, deltaBusy;
hostOp cmdOp;
logic [7:0] cmdAddr, cmdData, rdData;
logic [LEVEL_W-1:0] level;
cmdEntry cmdTable [TABLE_LEN];
int seed = 32'h65b3;
int modelLevel;

apuSystem UUT (.*);

always #(CLK_PERIOD / 2) clk = ~clk;

task automatic failRun(input string line);
	$display("%s", line);
	$display("Errors found");
	$fatal(1, "Run stopped at the first error.");
endtask

// Drives one command and returns right after the accepting edge.
task automatic sendCommand(input hostOp op, input logic [7:0] addr, input logic [7:0] data);
	@(posedge clk);
	#5;
	cmdValid = 1'b1;
	cmdOp = op;
	cmdAddr = addr;
	cmdData = data;
	@(negedge clk);
	while (!cmdReady)
		@(negedge clk);
	@(posedge clk);
	#5 cmdValid = 1'b0;
endtask

task automatic applyEntry(input int i);
	int n;
	sendCommand(cmdTable[i].op, cmdTable[i].addr, cmdTable[i].data);
	if (cmdTable[i].op == opReadRam) begin
		for (n = 0; n < CMD_CYCLES && !rdValid; n++)
			@(negedge clk);
		assert (rdValid) else failRun("Read data never came back from the sample memory.");
		assert (rdData == cmdTable[i].expRead) else failRun($sformatf(
			"[FAIL] %0t ns: read of %0h gave %0h, expected %0h",
			$time, cmdTable[i].addr, rdData, cmdTable[i].expRead));
	end
endtask

// Clamped delta rule over the bytes written by the table, LSB first.
function automatic int expectedDeltaLevel();
	int lvl;
	int b;
	int k;
	lvl = DELTA_RESET_LEVEL;
	for (b = 0; b < NUM_BYTES; b++)
		for (k = 0; k < 8; k++)
			if (cmdTable[b].data[k])
				lvl = (lvl + 2 > DELTA_MAX) ? lvl : lvl + 2;
			else
				lvl = (lvl - 2 < 0) ? lvl : lvl - 2;
	return lvl;
endfunction

task automatic startPlayback();
	int n;
	sendCommand(opWriteReg, 8'(regDeltaGo), 8'd0);
	for (n = 0; n < 4 && !deltaBusy; n++)
		@(negedge clk);
	assert (deltaBusy) else failRun("Delta playback did not start after the go command.");
endtask

task automatic checkPlaybackEnd();
	int n;
	for (n = 0; n < PLAY_CYCLES + 2 * NUM_BYTES * CMD_CYCLES && deltaBusy; n++)
		@(negedge clk);
	assert (!deltaBusy) else failRun("Delta playback never finished.");
	@(negedge clk);                                  // Mixer registers the level once more.
	assert (level == modelLevel) else failRun($sformatf(
		"[FAIL] %0t ns: level %0d after playback, expected %0d", $time, level, modelLevel));
endtask

initial begin
	int i;
	int highCount;
	logic lowSeen, highSeen;
	clk = 1'b0;
	rstN = 1'b0;
	cmdValid = 1'b0;
	cmdOp = opWriteRam;
	cmdAddr = '0;
	cmdData = '0;
	lowSeen = 1'b0;
	highSeen = 1'b0;
	highCount = 0;
	for (i = 0; i < NUM_BYTES; i++) begin
		cmdTable[i] = '{opWriteRam, SAMPLE_BASE + 8'(i), 8'($random(seed)), 8'h00};
		cmdTable[NUM_BYTES + i] = '{opReadRam, SAMPLE_BASE + 8'(i), 8'h00, cmdTable[i].data};
	end
	modelLevel = expectedDeltaLevel();
	repeat (8) @(posedge clk);
	#5 rstN = 1'b1;
	@(negedge clk);
	assert (cmdReady && !rdValid && !deltaBusy && !aout && level == DELTA_RESET_LEVEL)
		else failRun($sformatf("[FAIL] %0t ns: wrong outputs after reset, level %0d",
			$time, level));
	for (i = 0; i < TABLE_LEN; i++)
		applyEntry(i);
	sendCommand(opWriteReg, 8'(regPulsePeriod), 8'(PULSE_PERIOD));
	sendCommand(opWriteReg, 8'(regPulseDuty), 8'd2);
	sendCommand(opWriteReg, 8'(regPulseVolume), 8'd5);
	repeat (8 * (PULSE_PERIOD + 1)) @(negedge clk);  // Let the sequencer settle.
	repeat (8 * (PULSE_PERIOD + 1)) begin
		@(negedge clk);
		assert (level == DELTA_RESET_LEVEL || level == DELTA_RESET_LEVEL + 5) else failRun(
			$sformatf("[FAIL] %0t ns: pulse level %0d out of range", $time, level));
		if (level == DELTA_RESET_LEVEL)
			lowSeen = 1'b1;
		else
			highSeen = 1'b1;
	end
	assert (lowSeen && highSeen) else failRun("Pulse channel did not toggle the level.");
	sendCommand(opWriteReg, 8'(regPulseVolume), 8'd0);
	sendCommand(opWriteReg, 8'(regDeltaStart), SAMPLE_BASE);
	sendCommand(opWriteReg, 8'(regDeltaLength), 8'(NUM_BYTES));
	startPlayback();
	checkPlaybackEnd();
	startPlayback();                                 // Rerun under host contention.
	while (deltaBusy)                                // Reads span every sample fetch.
		for (i = NUM_BYTES; i < TABLE_LEN; i++)
			applyEntry(i);
	checkPlaybackEnd();
	repeat (256) begin
		@(negedge clk);
		highCount += aout;
	end
	assert (highCount == modelLevel) else failRun($sformatf(
		"[FAIL] %0t ns: aout high %0d of 256 cycles, expected %0d", $time, highCount, modelLevel));
	$display("No errors");
	$finish;
end

initial begin
	#(RUN_CYCLES * CLK_PERIOD);
	failRun("Timeout: the run did not finish within its time limit.");
end

endmodule

// ==== files.f ====
hdl/apuPkg.sv
hdl/sampleBusIf.sv
hdl/sampleRam.sv
hdl/busArbiter.sv
hdl/hostPort.sv
hdl/pulseChannel.sv
hdl/deltaChannel.sv
hdl/apuMixPwm.sv
hdl/apuSystem.sv
bench/apuSystem_asserts.sv
bench/apuSystemTb.sv
